// File: wasm_core.f
+incdir+test
logic/wasm_pkg.sv
logic/code_memory.sv
logic/leb128_decoder.sv
logic/instr_fetch.sv
logic/operand_stack.sv
logic/exec_unit.sv
logic/wasm_core.sv
test/wasm_core_tb.sv

// File: test/wasm_programs.svh
`ifndef WASM_PROGRAMS_SVH
`define WASM_PROGRAMS_SVH

// One program per entry, with the outcome it must stop at
typedef struct {
  string       name;
  int          entry;
  int          len;
  logic [7:0]  code [32];
  trap_t       exp_trap;
  logic [63:0] exp_result;
  value_tag_t  exp_type;
  logic        exp_empty;
} program_t;

task automatic build_fixed_programs();
  // Hand-encoded immediate, kept apart from the encoder
  start_program("i32.const -1000", 0);
  emit_bytes(64'h41_98_78_0b, 4);
  add_expected(TRAP_ENDED, 64'hffff_fc18, TAG_I32, 1'b0);
  unary_program("i32.const min then nop", TAG_I32, 64'h8000_0000, OP_NOP);
  add_expected(TRAP_ENDED, 64'h8000_0000, TAG_I32, 1'b0);
  unary_program("i64.const full width", TAG_I64, 64'hc123_4567_89ab_cdef, OP_NOP);
  add_expected(TRAP_ENDED, 64'hc123_4567_89ab_cdef, TAG_I64, 1'b0);
  binary_program("i32.add wraps", TAG_I32, 64'h7fff_ffff, TAG_I32, 64'h1, OP_I32_ADD);
  add_expected(TRAP_ENDED, 64'h8000_0000, TAG_I32, 1'b0);
  binary_program("i32.sub wraps", TAG_I32, 64'h5, TAG_I32, 64'h7, OP_I32_SUB);
  add_expected(TRAP_ENDED, 64'hffff_fffe, TAG_I32, 1'b0);
  binary_program("i64.add", TAG_I64, 64'h3fff_ffff_ffff_ffff, TAG_I64,
                 64'h3fff_ffff_ffff_ffff, OP_I64_ADD);
  add_expected(TRAP_ENDED, 64'h7fff_ffff_ffff_fffe, TAG_I64, 1'b0);
  binary_program("i64.sub", TAG_I64, 64'h3, TAG_I64, 64'ha, OP_I64_SUB);
  add_expected(TRAP_ENDED, 64'hffff_ffff_ffff_fff9, TAG_I64, 1'b0);
  binary_program("i32.eq equal", TAG_I32, 64'h5, TAG_I32, 64'h5, OP_I32_EQ);
  add_expected(TRAP_ENDED, 64'h1, TAG_I32, 1'b0);
  binary_program("i32.ne equal", TAG_I32, 64'h5, TAG_I32, 64'h5, OP_I32_NE);
  add_expected(TRAP_ENDED, 64'h0, TAG_I32, 1'b0);
  unary_program("i32.eqz zero", TAG_I32, 64'h0, OP_I32_EQZ);
  add_expected(TRAP_ENDED, 64'h1, TAG_I32, 1'b0);
  unary_program("i32.eqz minus one", TAG_I32, 64'hffff_ffff, OP_I32_EQZ);
  add_expected(TRAP_ENDED, 64'h0, TAG_I32, 1'b0);
  // Operands differ only above bit 31
  binary_program("i64.eq upper", TAG_I64, 64'h1_0000_0005, TAG_I64, 64'h5, OP_I64_EQ);
  add_expected(TRAP_ENDED, 64'h0, TAG_I32, 1'b0);
  binary_program("i64.ne upper", TAG_I64, 64'h1_0000_0005, TAG_I64, 64'h5, OP_I64_NE);
  add_expected(TRAP_ENDED, 64'h1, TAG_I32, 1'b0);
  unary_program("i64.eqz upper", TAG_I64, 64'h1_0000_0000, OP_I64_EQZ);
  add_expected(TRAP_ENDED, 64'h0, TAG_I32, 1'b0);
  select_program("select nonzero", TAG_I64, 64'h1122_3344_5566_7788, TAG_I64, -64'sd5, 7);
  add_expected(TRAP_ENDED, 64'h1122_3344_5566_7788, TAG_I64, 1'b0);
  select_program("select zero", TAG_I32, 64'd11, TAG_I32, 64'd22, 0);
  add_expected(TRAP_ENDED, 64'd22, TAG_I32, 1'b0);
  unary_program("drop to empty", TAG_I32, 64'h7, OP_DROP);
  add_expected(TRAP_ENDED, 64'h0, TAG_I32, 1'b1);
  unary_program("add with one operand", TAG_I32, 64'h3, OP_I32_ADD);
  add_expected(TRAP_STACK_EMPTY, 64'h3, TAG_I32, 1'b0);
  binary_program("i32.add on i64", TAG_I32, 64'h1, TAG_I64, 64'h2, OP_I32_ADD);
  add_expected(TRAP_TYPE_MISMATCH, 64'h2, TAG_I64, 1'b0);
  select_program("select mixed tags", TAG_I32, 64'h1, TAG_I64, 64'h2, 1);
  add_expected(TRAP_TYPES_MISMATCH, 64'h1, TAG_I32, 1'b0);
  start_program("nine constants", 4);
  for (int i = 1; i <= 9; i++) begin
    emit_const(TAG_I32, 64'(i));
  end
  emit_byte(OP_END);
  add_expected(TRAP_STACK_FULL, 64'h8, TAG_I32, 1'b0);
  unary_program("unreachable", TAG_I32, 64'h4, OP_UNREACHABLE);
  add_expected(TRAP_UNREACHABLE, 64'h4, TAG_I32, 1'b0);
  start_program("unknown opcode", 20);
  emit_bytes(64'h01_ff_0b, 3);
  add_expected(TRAP_UNKNOWN_OPCODE, 64'h0, TAG_I32, 1'b1);
  // The end at 56 lies inside the last nine bytes
  start_program("end past memory window", 50);
  emit_bytes(64'h01_01_01_01_01_01_0b, 7);
  add_expected(TRAP_ROM_ERROR, 64'h0, TAG_I32, 1'b1);
endtask

`endif

// File: test/wasm_core_tb.sv
`timescale 1ns/1ps

module wasm_core_tb
  import wasm_pkg::*;
();

  logic                   clk;
  logic                   reset;
  logic [CODE_ADDR_W-1:0] entry_pc;
  logic                   prog_we;
  logic [CODE_ADDR_W-1:0] prog_addr;
  logic [7:0]             prog_data;
  logic [63:0]            result;
  value_tag_t             result_type;
  logic                   result_empty;
  trap_t                  trap;

  int pass_count;
  int fail_count;
  int test_errors;

  wasm_core u_wasm_core (
    .clk          (clk),
    .reset        (reset),
    .entry_pc     (entry_pc),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .result       (result),
    .result_type  (result_type),
    .result_empty (result_empty),
    .trap         (trap)
  );

  always #4 clk = ~clk;

  `include "wasm_programs.svh"

  program_t programs[$];
  program_t cur;

  task automatic start_program(input string name, input int entry);
    cur.name  = name;
    cur.entry = entry;
    cur.len   = 0;
  endtask

  task automatic emit_byte(input logic [7:0] b);
    cur.code[cur.len] = b;
    cur.len++;
  endtask

  // First byte sits in the highest of the n used positions
  task automatic emit_bytes(input logic [63:0] seq, input int n);
    for (int i = n - 1; i >= 0; i--) begin
      emit_byte(seq[8*i +: 8]);
    end
  endtask

  // Signed LEB128, seven bits a byte until only sign bits remain
  task automatic emit_const(input value_tag_t tag, input logic [63:0] v);
    logic [63:0] rest;
    logic [7:0]  b;
    logic        last;
    rest = (tag == TAG_I32) ? {{32{v[31]}}, v[31:0]} : v;
    emit_byte((tag == TAG_I32) ? OP_I32_CONST : OP_I64_CONST);
    last = 1'b0;
    while (!last) begin
      b    = {1'b0, rest[6:0]};
      rest = $signed(rest) >>> 7;
      last = (rest == '0 && !b[6]) || (rest == '1 && b[6]);
      emit_byte(last ? b : (b | 8'h80));
    end
  endtask

  task automatic unary_program(input string name, input value_tag_t tag, input logic [63:0] a,
                               input logic [7:0] op);
    start_program(name, programs.size() % 16);
    emit_const(tag, a);
    emit_byte(op);
    emit_byte(OP_END);
  endtask

  task automatic binary_program(input string name, input value_tag_t tag_a,
                                input logic [63:0] a, input value_tag_t tag_b,
                                input logic [63:0] b, input logic [7:0] op);
    start_program(name, programs.size() % 16);
    emit_const(tag_a, a);
    emit_const(tag_b, b);
    emit_byte(op);
    emit_byte(OP_END);
  endtask

  task automatic select_program(input string name, input value_tag_t tag_a,
                                input logic [63:0] a, input value_tag_t tag_b,
                                input logic [63:0] b, input logic [31:0] cond);
    start_program(name, programs.size() % 16);
    emit_const(tag_a, a);
    emit_const(tag_b, b);
    emit_const(TAG_I32, 64'(cond));
    emit_bytes({OP_SELECT, OP_END}, 2);
  endtask

  task automatic add_expected(input trap_t t, input logic [63:0] r, input value_tag_t ty,
                              input logic e);
    cur.exp_trap   = t;
    cur.exp_result = r;
    cur.exp_type   = ty;
    cur.exp_empty  = e;
    programs.push_back(cur);
  endtask

  task automatic build_random_programs();
    logic [31:0] a32;
    logic [31:0] b32;
    logic [63:0] a64;
    logic [63:0] b64;
    a32 = $urandom;
    b32 = $urandom;
    a64 = {$urandom, $urandom};
    b64 = {$urandom, $urandom};
    // Nine LEB bytes hold 63 bits, so bit 63 repeats bit 62
    a64[63] = a64[62];
    b64[63] = b64[62];
    binary_program("random i32.add", TAG_I32, 64'(a32), TAG_I32, 64'(b32), OP_I32_ADD);
    add_expected(TRAP_ENDED, {32'd0, a32 + b32}, TAG_I32, 1'b0);
    binary_program("random i32.sub", TAG_I32, 64'(a32), TAG_I32, 64'(b32), OP_I32_SUB);
    add_expected(TRAP_ENDED, {32'd0, a32 - b32}, TAG_I32, 1'b0);
    binary_program("random i64.add", TAG_I64, a64, TAG_I64, b64, OP_I64_ADD);
    add_expected(TRAP_ENDED, a64 + b64, TAG_I64, 1'b0);
    binary_program("random i64.sub", TAG_I64, a64, TAG_I64, b64, OP_I64_SUB);
    add_expected(TRAP_ENDED, a64 - b64, TAG_I64, 1'b0);
  endtask

  task automatic check_value(input string sig, input logic [63:0] got, input logic [63:0] exp);
    if (got !== exp) begin
      $display("ERR time=%0t %s got=%h expected=%h", $time, sig, got, exp);
      test_errors++;
    end
  endtask

  task automatic run_program(input program_t p);
    int cycles;
    test_errors = 0;
    // Program is written while reset holds the core
    @(posedge clk);
    reset    <= 1'b1;
    entry_pc <= CODE_ADDR_W'(p.entry);
    for (int i = 0; i < p.len; i++) begin
      @(posedge clk);
      prog_we   <= 1'b1;
      prog_addr <= CODE_ADDR_W'(p.entry + i);
      prog_data <= p.code[i];
    end
    @(posedge clk);
    prog_we <= 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;

    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (trap == TRAP_NONE && cycles < 500);

    if (trap == TRAP_NONE) begin
      $display("Timeout: %s did not stop within 500 cycles", p.name);
      test_errors++;
    end else begin
      check_value("trap", 64'(trap), 64'(p.exp_trap));
      check_value("result_empty", 64'(result_empty), 64'(p.exp_empty));
      if (!p.exp_empty) begin
        check_value("result", result, p.exp_result);
        check_value("result_type", 64'(result_type), 64'(p.exp_type));
      end
    end

    if (test_errors == 0) begin
      pass_count++;
      $display("PASS %s", p.name);
    end else begin
      fail_count++;
      $display("FAIL %s", p.name);
    end
  endtask

  initial begin
    int unsigned seed_ret;
    clk        = 1'b0;
    reset      = 1'b1;
    entry_pc   = '0;
    prog_we    = 1'b0;
    prog_addr  = '0;
    prog_data  = '0;
    pass_count = 0;
    fail_count = 0;
    seed_ret   = $urandom(32'h6a87);

    build_fixed_programs();
    build_random_programs();
    foreach (programs[i]) begin
      run_program(programs[i]);
    end

    $display("Tests passed: %0d, failed: %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

// File: logic/wasm_core.sv
`timescale 1ns/1ps

module wasm_core
  import wasm_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [CODE_ADDR_W-1:0] entry_pc,
  input  logic                   prog_we,
  input  logic [CODE_ADDR_W-1:0] prog_addr,
  input  logic [7:0]             prog_data,
  output logic [63:0]            result,
  output value_tag_t             result_type,
  output logic                   result_empty,
  output trap_t                  trap
);

  logic                   instr_valid;
  opcode_t                instr_opcode;
  logic [63:0]            instr_imm;
  logic                   fetch_error;
  logic                   exec_done;
  stack_op_t              stack_op;
  typed_value_t           stack_wdata;
  typed_value_t           tos;
  typed_value_t           nos;
  typed_value_t           third;
  logic [STACK_CNT_W-1:0] depth;
  logic                   empty;
  logic                   full;

  instr_fetch u_instr_fetch (
    .clk          (clk),
    .reset        (reset),
    .entry_pc     (entry_pc),
    .prog_we      (prog_we),
    .prog_addr    (prog_addr),
    .prog_data    (prog_data),
    .exec_done    (exec_done),
    .instr_valid  (instr_valid),
    .instr_opcode (instr_opcode),
    .instr_imm    (instr_imm),
    .fetch_error  (fetch_error)
  );

  operand_stack u_operand_stack (
    .clk   (clk),
    .reset (reset),
    .op    (stack_op),
    .wdata (stack_wdata),
    .tos   (tos),
    .nos   (nos),
    .third (third),
    .depth (depth),
    .empty (empty),
    .full  (full)
  );

  exec_unit u_exec_unit (
    .clk          (clk),
    .reset        (reset),
    .instr_valid  (instr_valid),
    .instr_opcode (instr_opcode),
    .instr_imm    (instr_imm),
    .fetch_error  (fetch_error),
    .tos          (tos),
    .nos          (nos),
    .third        (third),
    .depth        (depth),
    .full         (full),
    .stack_op     (stack_op),
    .stack_wdata  (stack_wdata),
    .exec_done    (exec_done),
    .trap         (trap)
  );

  // Result is whatever sits on top once the run stops
  assign result       = tos.payload;
  assign result_type  = tos.tag;
  assign result_empty = empty;

endmodule

// File: logic/exec_unit.sv
`timescale 1ns/1ps

module exec_unit
  import wasm_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   instr_valid,
  input  opcode_t                instr_opcode,
  input  logic [63:0]            instr_imm,
  input  logic                   fetch_error,
  input  typed_value_t           tos,
  input  typed_value_t           nos,
  input  typed_value_t           third,
  input  logic [STACK_CNT_W-1:0] depth,
  input  logic                   full,
  output stack_op_t              stack_op,
  output typed_value_t           stack_wdata,
  output logic                   exec_done,
  output trap_t                  trap
);

  stack_op_t              n_op;
  typed_value_t           n_data;
  trap_t                  op_trap;
  trap_t                  n_trap;
  logic [STACK_CNT_W-1:0] need;
  logic                   pushes;
  logic                   tag_ok;
  logic                   sel_ok;
  logic [63:0]            sum;
  logic [63:0]            diff;

  function automatic typed_value_t make_i32(input logic [31:0] v);
    return '{tag: TAG_I32, payload: {32'd0, v}};
  endfunction

  // Second operand is the later push, so sub is nos minus tos
  assign sum  = nos.payload + tos.payload;
  assign diff = nos.payload - tos.payload;

  always_comb begin
    n_op    = SOP_NONE;
    n_data  = tos;
    op_trap = TRAP_NONE;
    need    = '0;
    pushes  = 1'b0;
    tag_ok  = 1'b1;
    sel_ok  = 1'b1;

    case (instr_opcode)
      OP_NOP: ;
      OP_UNREACHABLE: op_trap = TRAP_UNREACHABLE;
      OP_END:         op_trap = TRAP_ENDED;
      OP_DROP: begin
        need = STACK_CNT_W'(1);
        n_op = SOP_POP;
      end
      OP_I32_CONST, OP_I64_CONST: begin
        pushes = 1'b1;
        n_op   = SOP_PUSH;
        if (instr_opcode == OP_I32_CONST) begin
          n_data = make_i32(instr_imm[31:0]);
        end else begin
          n_data = '{tag: TAG_I64, payload: instr_imm};
        end
      end
      OP_I32_EQZ, OP_I64_EQZ: begin
        need   = STACK_CNT_W'(1);
        n_op   = SOP_REPLACE;
        if (instr_opcode == OP_I32_EQZ) begin
          tag_ok = (tos.tag == TAG_I32);
          n_data = make_i32({31'd0, tos.payload[31:0] == 32'd0});
        end else begin
          tag_ok = (tos.tag == TAG_I64);
          n_data = make_i32({31'd0, tos.payload == 64'd0});
        end
      end
      OP_I32_EQ, OP_I32_NE, OP_I32_ADD, OP_I32_SUB: begin
        need   = STACK_CNT_W'(2);
        n_op   = SOP_POP_REPLACE;
        tag_ok = (tos.tag == TAG_I32) && (nos.tag == TAG_I32);
        case (instr_opcode)
          OP_I32_EQ:  n_data = make_i32({31'd0, nos.payload[31:0] == tos.payload[31:0]});
          OP_I32_NE:  n_data = make_i32({31'd0, nos.payload[31:0] != tos.payload[31:0]});
          OP_I32_ADD: n_data = make_i32(sum[31:0]);
          default:    n_data = make_i32(diff[31:0]);
        endcase
      end
      OP_I64_EQ, OP_I64_NE, OP_I64_ADD, OP_I64_SUB: begin
        need   = STACK_CNT_W'(2);
        n_op   = SOP_POP_REPLACE;
        tag_ok = (tos.tag == TAG_I64) && (nos.tag == TAG_I64);
        case (instr_opcode)
          OP_I64_EQ:  n_data = make_i32({31'd0, nos.payload == tos.payload});
          OP_I64_NE:  n_data = make_i32({31'd0, nos.payload != tos.payload});
          OP_I64_ADD: n_data = '{tag: TAG_I64, payload: sum};
          default:    n_data = '{tag: TAG_I64, payload: diff};
        endcase
      end
      OP_SELECT: begin
        // Condition on top, first pushed value is third
        need   = STACK_CNT_W'(3);
        n_op   = SOP_POP2_REPLACE;
        tag_ok = (tos.tag == TAG_I32);
        sel_ok = (nos.tag == third.tag);
        n_data = (tos.payload[31:0] != 32'd0) ? third : nos;
      end
      default: op_trap = TRAP_UNKNOWN_OPCODE;
    endcase

    // Trap causes in priority order
    if (fetch_error) n_trap = TRAP_ROM_ERROR;
    else if (depth < need) n_trap = TRAP_STACK_EMPTY;
    else if (pushes && full) n_trap = TRAP_STACK_FULL;
    else if (!tag_ok) n_trap = TRAP_TYPE_MISMATCH;
    else if (!sel_ok) n_trap = TRAP_TYPES_MISMATCH;
    else n_trap = op_trap;
  end

  // A trap withholds exec_done, so fetch never strobes again
  always_ff @(posedge clk) begin
    if (reset) begin
      stack_op  <= SOP_NONE;
      exec_done <= 1'b0;
      trap      <= TRAP_NONE;
    end else begin
      stack_op  <= SOP_NONE;
      exec_done <= 1'b0;
      if (instr_valid) begin
        trap <= n_trap;
        if (n_trap == TRAP_NONE) begin
          stack_op  <= n_op;
          exec_done <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (instr_valid) begin
      stack_wdata <= n_data;
    end
  end

  a_trap_sticky: assert property (
    @(posedge clk) disable iff (reset) (trap != TRAP_NONE) |=> $stable(trap)
  ) else $error("trap changed after being raised");

endmodule

// File: logic/operand_stack.sv
`timescale 1ns/1ps

module operand_stack
  import wasm_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  stack_op_t              op,
  input  typed_value_t           wdata,
  output typed_value_t           tos,
  output typed_value_t           nos,
  output typed_value_t           third,
  output logic [STACK_CNT_W-1:0] depth,
  output logic                   empty,
  output logic                   full
);

  typed_value_t mem [STACK_DEPTH];

  logic [STACK_PTR_W-1:0] top_idx;
  logic [STACK_CNT_W-1:0] min_depth;

  assign top_idx = STACK_PTR_W'(depth - 1'b1);
  assign empty   = (depth == '0);
  assign full    = (depth == STACK_CNT_W'(STACK_DEPTH));

  // Entries below the bottom read as zero
  assign tos   = (depth >= 1) ? mem[top_idx] : '0;
  assign nos   = (depth >= 2) ? mem[top_idx - 1'b1] : '0;
  assign third = (depth >= 3) ? mem[top_idx - 2'd2] : '0;

  always_ff @(posedge clk) begin
    if (reset) begin
      depth <= '0;
    end else begin
      case (op)
        SOP_PUSH:                 depth <= depth + 1'b1;
        SOP_POP, SOP_POP_REPLACE: depth <= depth - 1'b1;
        SOP_POP2_REPLACE:         depth <= depth - 2'd2;
        default: ;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    case (op)
      SOP_PUSH:         mem[STACK_PTR_W'(depth)] <= wdata;
      SOP_REPLACE:      mem[top_idx] <= wdata;
      SOP_POP_REPLACE:  mem[top_idx - 1'b1] <= wdata;
      SOP_POP2_REPLACE: mem[top_idx - 2'd2] <= wdata;
      default: ;
    endcase
  end

  // Entries each command needs to be present
  always_comb begin
    case (op)
      SOP_POP, SOP_REPLACE: min_depth = STACK_CNT_W'(1);
      SOP_POP_REPLACE:      min_depth = STACK_CNT_W'(2);
      SOP_POP2_REPLACE:     min_depth = STACK_CNT_W'(3);
      default:              min_depth = '0;
    endcase
  end

  a_no_underflow: assert property (
    @(posedge clk) disable iff (reset) depth >= min_depth
  ) else $error("stack command pops below the bottom");

  a_no_overflow: assert property (
    @(posedge clk) disable iff (reset) (op == SOP_PUSH) |-> !full
  ) else $error("push onto a full stack");

endmodule

// File: logic/instr_fetch.sv
`timescale 1ns/1ps

module instr_fetch
  import wasm_pkg::*;
(
  input  logic                   clk,
  input  logic                   reset,
  input  logic [CODE_ADDR_W-1:0] entry_pc,
  input  logic                   prog_we,
  input  logic [CODE_ADDR_W-1:0] prog_addr,
  input  logic [7:0]             prog_data,
  input  logic                   exec_done,
  output logic                   instr_valid,
  output opcode_t                instr_opcode,
  output logic [63:0]            instr_imm,
  output logic                   fetch_error
);

  typedef enum logic [1:0] {
    F_LOAD,
    F_DECODE,
    F_WAIT
  } fetch_state_t;

  fetch_state_t state;

  logic [CODE_ADDR_W-1:0]    pc;
  logic [8*WINDOW_BYTES-1:0] window;
  logic                      out_of_range;
  logic [7:0]                op_byte;
  logic                      is_const;
  logic [63:0]               leb_value;
  logic [3:0]                leb_len;
  logic [3:0]                imm_len;

  // Program loading is only honoured while the core is held in reset
  code_memory #(
    .ADDR_W    (CODE_ADDR_W),
    .WIN_BYTES (WINDOW_BYTES)
  ) u_code_memory (
    .clk          (clk),
    .we           (prog_we && reset),
    .waddr        (prog_addr),
    .wdata        (prog_data),
    .raddr        (pc),
    .window       (window),
    .out_of_range (out_of_range)
  );

  leb128_decoder u_leb128_decoder (
    .bytes  (window[8*WINDOW_BYTES-1:8]),
    .value  (leb_value),
    .length (leb_len)
  );

  assign op_byte  = window[7:0];
  assign is_const = (op_byte == OP_I32_CONST) || (op_byte == OP_I64_CONST);
  assign imm_len  = is_const ? leb_len : 4'd0;

  // Window follows pc every cycle, so waiting keeps it current
  always_ff @(posedge clk) begin
    if (reset) begin
      state       <= F_LOAD;
      pc          <= entry_pc;
      instr_valid <= 1'b0;
    end else begin
      instr_valid <= 1'b0;
      case (state)
        F_LOAD: begin
          state <= F_DECODE;
        end
        F_DECODE: begin
          instr_valid <= 1'b1;
          pc          <= pc + CODE_ADDR_W'(imm_len) + CODE_ADDR_W'(1);
          state       <= F_WAIT;
        end
        default: begin
          if (exec_done) begin
            state <= F_DECODE;
          end
        end
      endcase
    end
  end

  // Instruction fields, held until the next strobe
  always_ff @(posedge clk) begin
    if (state == F_DECODE) begin
      instr_opcode <= opcode_t'(op_byte);
      instr_imm    <= is_const ? leb_value : 64'd0;
      fetch_error  <= out_of_range;
    end
  end

  a_single_strobe: assert property (
    @(posedge clk) disable iff (reset) instr_valid |=> !instr_valid
  ) else $error("instr_valid held for two cycles");

endmodule

// File: logic/leb128_decoder.sv
`timescale 1ns/1ps

module leb128_decoder (
  input  logic [71:0] bytes,
  output logic [63:0] value,
  output logic [3:0]  length
);

  always_comb begin
    logic [63:0] acc;
    logic        done;
    logic        sign;
    logic [3:0]  len;

    acc  = '0;
    done = 1'b0;
    sign = 1'b0;
    len  = 4'd0;

    // Seven payload bits per byte, low group first
    for (int i = 0; i < 9; i++) begin
      if (!done) begin
        acc  = acc | (64'(bytes[8*i +: 7]) << (7 * i));
        sign = bytes[8*i + 6];
        len  = 4'(i + 1);
        done = !bytes[8*i + 7];
      end
    end

    // Sign bit of the last group fills everything above it
    if (sign) begin
      acc = acc | ({64{1'b1}} << (7 * len));
    end

    value  = acc;
    length = len;
  end

endmodule

// File: logic/code_memory.sv
`timescale 1ns/1ps

module code_memory #(
  parameter int ADDR_W    = 6,
  parameter int WIN_BYTES = 10
) (
  input  logic                   clk,
  input  logic                   we,
  input  logic [ADDR_W-1:0]      waddr,
  input  logic [7:0]             wdata,
  input  logic [ADDR_W-1:0]      raddr,
  output logic [8*WIN_BYTES-1:0] window,
  output logic                   out_of_range
);

  logic [7:0] mem [2**ADDR_W];

  always_ff @(posedge clk) begin
    if (we) begin
      mem[waddr] <= wdata;
    end
  end

  // Byte 0 of the window is the byte at raddr, in the low bits
  always_ff @(posedge clk) begin
    for (int i = 0; i < WIN_BYTES; i++) begin
      window[8*i +: 8] <= mem[ADDR_W'(raddr + i)];
    end
    // Last window byte would wrap past the top of memory
    out_of_range <= ({1'b0, raddr} + (ADDR_W + 1)'(WIN_BYTES - 1)) > (ADDR_W + 1)'(2**ADDR_W - 1);
  end

endmodule

// File: logic/wasm_pkg.sv
package wasm_pkg;

  // Program memory and fetch window
  localparam int CODE_ADDR_W  = 6;
  localparam int WINDOW_BYTES = 10;

  // Operand stack sizing
  localparam int STACK_DEPTH = 8;
  localparam int STACK_CNT_W = 4;
  localparam int STACK_PTR_W = $clog2(STACK_DEPTH);

  typedef enum logic [1:0] {
    TAG_I32 = 2'd0,
    TAG_I64 = 2'd1,
    TAG_F32 = 2'd2,
    TAG_F64 = 2'd3
  } value_tag_t;

  // i32 payloads sit in the low half with the upper half zero
  typedef struct packed {
    value_tag_t  tag;
    logic [63:0] payload;
  } typed_value_t;

  // Standard WebAssembly encodings
  typedef enum logic [7:0] {
    OP_UNREACHABLE = 8'h00,
    OP_NOP         = 8'h01,
    OP_END         = 8'h0b,
    OP_DROP        = 8'h1a,
    OP_SELECT      = 8'h1b,
    OP_I32_CONST   = 8'h41,
    OP_I64_CONST   = 8'h42,
    OP_I32_EQZ     = 8'h45,
    OP_I32_EQ      = 8'h46,
    OP_I32_NE      = 8'h47,
    OP_I64_EQZ     = 8'h50,
    OP_I64_EQ      = 8'h51,
    OP_I64_NE      = 8'h52,
    OP_I32_ADD     = 8'h6a,
    OP_I32_SUB     = 8'h6b,
    OP_I64_ADD     = 8'h7c,
    OP_I64_SUB     = 8'h7d
  } opcode_t;

  typedef enum logic [3:0] {
    TRAP_NONE           = 4'd0,
    TRAP_ENDED          = 4'd1,
    TRAP_UNREACHABLE    = 4'd2,
    TRAP_UNKNOWN_OPCODE = 4'd3,
    TRAP_TYPE_MISMATCH  = 4'd4,
    TRAP_TYPES_MISMATCH = 4'd5,
    TRAP_STACK_EMPTY    = 4'd6,
    TRAP_STACK_FULL     = 4'd7,
    TRAP_ROM_ERROR      = 4'd8
  } trap_t;

  // Replace forms write the top left after their pops
  typedef enum logic [2:0] {
    SOP_NONE         = 3'd0,
    SOP_PUSH         = 3'd1,
    SOP_POP          = 3'd2,
    SOP_REPLACE      = 3'd3,
    SOP_POP_REPLACE  = 3'd4,
    SOP_POP2_REPLACE = 3'd5
  } stack_op_t;

endpackage
